/* hw/line_buf_pkg.sv */
// Shared sizes and FSM state types for the line buffer, referenced with scoped names
package line_buf_pkg;

    // Default sample width in bits
    localparam int DW_DEF = 16;

    // Default RAM address width, the top bit selects the bank
    localparam int AW_DEF = 5;

    // Writer owns a bank in FILL and waits for the reader in HOLD
    typedef enum logic {
        FILL = 1'b0,
        HOLD = 1'b1
    } wr_state_t;

    // Reader is IDLE until a finished line arrives, then drains it
    typedef enum logic {
        IDLE  = 1'b0,
        DRAIN = 1'b1
    } rd_state_t;

endpackage

/* hw/ram_port_if.sv */
// One RAM port bundle, controller side drives address and write data, memory returns read data
`timescale 1ns/1ps

interface ram_port_if #(
    parameter int DW = 16,
    parameter int AW = 5
);

    logic [AW-1:0] addr;
    logic [DW-1:0] din;
    logic          wr;
    logic [DW-1:0] dout;

    // Writer or reader side
    modport ctrl (
        output addr,
        output din,
        output wr,
        input  dout
    );

    // RAM side
    modport mem (
        input  addr,
        input  din,
        input  wr,
        output dout
    );

endinterface

/* hw/tdp_ram.sv */
// True dual-port RAM with registered inputs and a four-cycle pipelined read on both ports
`timescale 1ns/1ps

module tdp_ram #(
    parameter int DW = 16,
    parameter int AW = 5
) (
    input  logic       clk,
    input  logic       rst_n,
    ram_port_if.mem    a,
    ram_port_if.mem    b
);

    localparam int DEPTH = 2 ** AW;

    // Input stage
    logic [AW-1:0] a_addr_s1;
    logic [AW-1:0] b_addr_s1;
    logic [DW-1:0] a_din_s1;
    logic [DW-1:0] b_din_s1;
    logic          a_wr_s1;
    logic          b_wr_s1;

    // Address stage and storage
    logic [DW-1:0] mem [DEPTH];
    logic [AW-1:0] a_addr_s2;
    logic [AW-1:0] b_addr_s2;

    // Read and output stages
    logic [DW-1:0] a_rd_s3;
    logic [DW-1:0] b_rd_s3;
    logic [DW-1:0] a_out_s4;
    logic [DW-1:0] b_out_s4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_addr_s1 <= '0;
            b_addr_s1 <= '0;
            a_din_s1  <= '0;
            b_din_s1  <= '0;
            a_wr_s1   <= 1'b0;
            b_wr_s1   <= 1'b0;
        end else begin
            a_addr_s1 <= a.addr;
            b_addr_s1 <= b.addr;
            a_din_s1  <= a.din;
            b_din_s1  <= b.din;
            a_wr_s1   <= a.wr;
            b_wr_s1   <= b.wr;
        end
    end

    // Writes land one edge after the input stage, so a read issued
    // a cycle later still finds the new word in the read stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            a_addr_s2 <= '0;
            b_addr_s2 <= '0;
        end else begin
            if (a_wr_s1) begin
                mem[a_addr_s1] <= a_din_s1;
            end
            if (b_wr_s1) begin
                mem[b_addr_s1] <= b_din_s1;
            end
            a_addr_s2 <= a_addr_s1;
            b_addr_s2 <= b_addr_s1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_rd_s3  <= '0;
            b_rd_s3  <= '0;
            a_out_s4 <= '0;
            b_out_s4 <= '0;
        end else begin
            a_rd_s3  <= mem[a_addr_s2];
            b_rd_s3  <= mem[b_addr_s2];
            a_out_s4 <= a_rd_s3;
            b_out_s4 <= b_rd_s3;
        end
    end

    assign a.dout = a_out_s4;
    assign b.dout = b_out_s4;

endmodule

/* hw/line_writer.sv */
// Stores strobed samples into the owned bank on port A and hands full lines to the reader
`timescale 1ns/1ps

module line_writer #(
    parameter int DW = 16,
    parameter int AW = 5
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    input  logic [DW-1:0] in_data,
    input  logic          busy,
    ram_port_if.ctrl      ram,
    output logic          line_ready,
    output logic          ready_bank,
    output logic          overrun
);

    // Offset width within one bank
    localparam int OW = AW - 1;

    line_buf_pkg::wr_state_t state;
    logic                    own_bank;
    logic [OW-1:0]           offset;
    logic                    accept;
    logic                    line_full;
    logic                    do_swap;

    assign accept    = in_valid && (state == line_buf_pkg::FILL);
    assign line_full = accept && (offset == {OW{1'b1}});

    // Swap on the completing sample, or later once the reader lets go
    assign do_swap = !busy && (line_full || (state == line_buf_pkg::HOLD));

    assign ram.addr = {own_bank, offset};
    assign ram.din  = in_data;
    assign ram.wr   = accept;

    // Samples arriving while held have nowhere to go
    assign overrun = in_valid && (state == line_buf_pkg::HOLD);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= line_buf_pkg::FILL;
            own_bank   <= 1'b0;
            offset     <= '0;
            line_ready <= 1'b0;
            ready_bank <= 1'b0;
        end else begin
            line_ready <= do_swap;
            if (do_swap) begin
                ready_bank <= own_bank;
                own_bank   <= ~own_bank;
                offset     <= '0;
                state      <= line_buf_pkg::FILL;
            end else if (line_full) begin
                // Reader still busy, keep the full bank until it frees up
                state <= line_buf_pkg::HOLD;
            end else if (accept) begin
                offset <= offset + 1'b1;
            end
        end
    end

endmodule

/* hw/line_reader.sv */
// Drains a finished bank over port B and strobes each sample out after the RAM latency
`timescale 1ns/1ps

module line_reader #(
    parameter int DW = 16,
    parameter int AW = 5
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          line_ready,
    input  logic          ready_bank,
    ram_port_if.ctrl      ram,
    output logic          busy,
    output logic          out_valid,
    output logic [DW-1:0] out_data,
    output logic          line_done
);

    localparam int OW  = AW - 1;
    // Matches the read pipeline of tdp_ram
    localparam int LAT = 4;

    line_buf_pkg::rd_state_t state;
    logic                    rd_bank;
    logic [OW-1:0]           offset;
    logic                    issuing;
    logic                    issue_last;
    logic [LAT-1:0]          vld_pipe;
    logic [LAT-1:0]          last_pipe;

    assign issue_last = issuing && (offset == {OW{1'b1}});

    // Port B only reads
    assign ram.addr = {rd_bank, offset};
    assign ram.din  = '0;
    assign ram.wr   = 1'b0;

    // Busy already in the handoff cycle so the writer cannot swap twice
    assign busy = line_ready || (state == line_buf_pkg::DRAIN);

    assign out_valid = vld_pipe[LAT-1];
    assign line_done = last_pipe[LAT-1];
    assign out_data  = ram.dout;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= line_buf_pkg::IDLE;
            rd_bank <= 1'b0;
            offset  <= '0;
            issuing <= 1'b0;
        end else begin
            case (state)
                line_buf_pkg::IDLE: begin
                    if (line_ready) begin
                        state   <= line_buf_pkg::DRAIN;
                        rd_bank <= ready_bank;
                        offset  <= '0;
                        issuing <= 1'b1;
                    end
                end
                line_buf_pkg::DRAIN: begin
                    if (issuing) begin
                        offset <= offset + 1'b1;
                        if (issue_last) begin
                            issuing <= 1'b0;
                        end
                    end
                    // Done once the last read has come back
                    if (line_done) begin
                        state <= line_buf_pkg::IDLE;
                    end
                end
                default: state <= line_buf_pkg::IDLE;
            endcase
        end
    end

    // Valid and last flags ride alongside the reads in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_pipe  <= '0;
            last_pipe <= '0;
        end else begin
            vld_pipe  <= {vld_pipe[LAT-2:0], issuing};
            last_pipe <= {last_pipe[LAT-2:0], issue_last};
        end
    end

endmodule

/* hw/line_buf_top.sv */
// Ping-pong line buffer top level, writer and reader share one dual-port RAM
`timescale 1ns/1ps

module line_buf_top #(
    parameter int DW = line_buf_pkg::DW_DEF,
    parameter int AW = line_buf_pkg::AW_DEF
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    input  logic [DW-1:0] in_data,
    output logic          out_valid,
    output logic [DW-1:0] out_data,
    output logic          line_done,
    output logic          overrun
);

    logic line_ready;
    logic ready_bank;
    logic busy;

    ram_port_if #(.DW(DW), .AW(AW)) port_a ();
    ram_port_if #(.DW(DW), .AW(AW)) port_b ();

    line_writer #(.DW(DW), .AW(AW)) u_line_writer (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .busy       (busy),
        .ram        (port_a.ctrl),
        .line_ready (line_ready),
        .ready_bank (ready_bank),
        .overrun    (overrun)
    );

    line_reader #(.DW(DW), .AW(AW)) u_line_reader (
        .clk        (clk),
        .rst_n      (rst_n),
        .line_ready (line_ready),
        .ready_bank (ready_bank),
        .ram        (port_b.ctrl),
        .busy       (busy),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .line_done  (line_done)
    );

    tdp_ram #(.DW(DW), .AW(AW)) u_tdp_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (port_a.mem),
        .b     (port_b.mem)
    );

endmodule

/* bench/line_buf_properties.sv */
// Concurrent line framing, latency, overrun and reset checks bound into the top level
`timescale 1ns/1ps

module line_buf_properties #(
    parameter int AW = 5
) (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    in_valid,
    input logic                    out_valid,
    input logic                    line_done,
    input logic                    overrun,
    input logic                    line_ready,
    input line_buf_pkg::wr_state_t wr_state,
    input line_buf_pkg::rd_state_t rd_state
);

    localparam int LINE_LEN = 2 ** (AW - 1);

    int   fail_count = 0;
    // Set once the first line has been handed to the reader
    logic seen_line;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_line <= 1'b0;
        end else if (line_ready) begin
            seen_line <= 1'b1;
        end
    end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !out_valid && !line_done && !overrun)
        else begin
            fail_count++;
            $error("outputs active during reset");
        end

    quiet_before_first_line: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_line |-> !out_valid && !line_done && !overrun)
        else begin
            fail_count++;
            $error("outputs active before the first line");
        end

    // One unbroken burst per line with line_done only on the last sample
    burst_shape: assert property (@(posedge clk) disable iff (!rst_n)
        line_ready |-> ##5 (out_valid && !line_done) [*LINE_LEN-1]
            ##1 (out_valid && line_done) ##1 !out_valid)
        else begin
            fail_count++;
            $error("line burst has the wrong shape");
        end

    start_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_valid) |-> $past(line_ready, 5))
        else begin
            fail_count++;
            $error("burst did not start five cycles after handoff");
        end

    // Drops only while the reader still holds the previous line
    overrun_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
        overrun |-> in_valid && (wr_state == line_buf_pkg::HOLD)
            && (rd_state == line_buf_pkg::DRAIN || $past(rd_state == line_buf_pkg::DRAIN)))
        else begin
            fail_count++;
            $error("overrun outside of a held sample");
        end

endmodule

bind line_buf_top line_buf_properties #(.AW(AW)) u_line_buf_properties (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .out_valid  (out_valid),
    .line_done  (line_done),
    .overrun    (overrun),
    .line_ready (line_ready),
    .wr_state   (u_line_writer.state),
    .rd_state   (u_line_reader.state)
);

/* bench/line_buf_tb.sv */
// Testbench for the line buffer, gapped lines then a continuous stream against a reference queue
`timescale 1ns/1ps

module line_buf_tb;

    localparam int DW       = line_buf_pkg::DW_DEF;
    localparam int AW       = line_buf_pkg::AW_DEF;
    localparam int LINE_LEN = 2 ** (AW - 1);
    localparam int HALF     = 20;
    localparam int TIMEOUT  = 400;

    logic          clk;
    logic          rst_n;
    logic          in_valid;
    logic [DW-1:0] in_data;
    logic          out_valid;
    logic [DW-1:0] out_data;
    logic          line_done;
    logic          overrun;

    logic [DW-1:0] ref_q [$];
    logic [DW-1:0] expected;
    int            kept_count;
    string         test_name;

    line_buf_top #(.DW(DW), .AW(AW)) u_line_buf_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .line_done (line_done),
        .overrun   (overrun)
    );

    always #HALF clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "line buffer test stopped");
    endtask

    task automatic drive(input logic valid, input logic [DW-1:0] data);
        @(posedge clk);
        #2;
        in_valid = valid;
        in_data  = data;
    endtask

    task automatic wait_line_done();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run("timeout waiting for line_done");
            end
        end while (!line_done);
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (ref_q.size() != 0) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run("timeout waiting for the kept samples to come out");
            end
        end
    endtask

    // Sampled just before the edge, drops are decided in the same cycle
    always begin
        @(posedge clk);
        #(2 * HALF - 1);
        if (u_line_buf_top.u_line_buf_properties.fail_count != 0) begin
            fail_run("a bound property assertion failed");
        end
        if (in_valid && !overrun) begin
            ref_q.push_back(in_data);
            kept_count++;
        end
        if (out_valid && ref_q.size() == 0) begin
            fail_run("output sample arrived with no kept input pending");
        end else if (out_valid) begin
            expected = ref_q.pop_front();
            assert (out_data == expected) else begin
                $display("mismatch %s expected %h actual %h", test_name, expected, out_data);
                fail_run("output data differs from the reference queue");
            end
        end
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        kept_count = 0;
        test_name  = "reset";
        void'($urandom(32'h4561f990));
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Reader is idle before every swap
        test_name = "gapped_lines";
        for (int line = 0; line < 4; line++) begin
            for (int i = 0; i < LINE_LEN; i++) begin
                repeat ($urandom_range(3)) drive(1'b0, '0);
                drive(1'b1, DW'($urandom));
            end
            drive(1'b0, '0);
            wait_line_done();
        end

        // One sample per cycle outruns the reader and forces HOLD
        test_name = "continuous_stream";
        for (int i = 0; i < 6 * LINE_LEN; i++) begin
            drive(1'b1, DW'($urandom));
        end
        drive(1'b0, '0);

        // Complete the partial line so every kept sample drains
        test_name = "line_top_up";
        for (int i = 0; i < TIMEOUT && (kept_count % LINE_LEN) != 0; i++) begin
            drive(1'b1, DW'($urandom));
            drive(1'b0, '0);
        end
        wait_drained();
        repeat (8) @(posedge clk);

        if (ref_q.size() != 0 || (kept_count % LINE_LEN) != 0) begin
            fail_run("kept samples never reached the output");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

/* line_buf.f */
hw/line_buf_pkg.sv
hw/ram_port_if.sv
hw/tdp_ram.sv
hw/line_writer.sv
hw/line_reader.sv
hw/line_buf_top.sv
bench/line_buf_properties.sv
bench/line_buf_tb.sv

/* Makefile */
# Verilator lint and simulation for the line buffer

VERILATOR  := verilator
TOP        := line_buf_tb
FILELIST   := line_buf.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
RUN_ARGS   := +verilator+error+limit+100

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
